//--- heap_stimulus.txt
# name op arrayId index in expectedOut expectedError, all numbers hex, idle leaves a gap
# ops 0 nop 1 alloc 2 free 3 write 4 read 5 size 6 push 7 pop 8 resize 9 add a less
# errors 0 none 1 notAllocated 2 noSpace 3 bounds 4 full 5 empty 6 tooLarge
allocFirst      1 0 0 000 000 0
allocSecond     1 0 0 000 001 0
allocThird      1 0 0 000 002 0
allocFourth     1 0 0 000 003 0
allocNoSpace    1 0 0 000 000 2
freeTwo         2 2 0 000 000 0
freeOne         2 1 0 000 000 0
reuseOne        1 0 0 000 001 0
reuseTwo        1 0 0 000 002 0
sizeReusedOne   5 1 0 000 000 0
sizeReusedTwo   5 2 0 000 000 0
idle
writeFar        3 0 5 123 123 0
sizeGrown       5 0 0 000 006 0
writeInside     3 0 2 0ab 0ab 0
readFar         4 0 5 000 123 0
readInside      4 0 2 000 0ab 0
readPastSize    4 0 6 000 000 3
push0           6 1 0 011 011 0
push1           6 1 0 022 022 0
push2           6 1 0 033 033 0
push3           6 1 0 044 044 0
push4           6 1 0 055 055 0
push5           6 1 0 066 066 0
push6           6 1 0 077 077 0
push7           6 1 0 088 088 0
pushFull        6 1 0 099 000 4
idle
addWrap         9 1 7 fa0 028 0
popAdded        7 1 0 000 028 0
lessSeven       a 1 0 050 004 0
resizeThree     8 1 0 003 003 0
lessThree       a 1 0 050 003 0
resizeTooLarge  8 1 0 009 000 6
sizeKept        5 1 0 000 003 0
popTwo          7 1 0 000 033 0
popOne          7 1 0 000 022 0
popZero         7 1 0 000 011 0
popEmpty        7 1 0 000 000 5
freeThree       2 3 0 000 000 0
readFreed       4 3 0 000 000 1
writeFreed      3 3 0 555 000 1
freeTwice       2 3 0 000 000 1
pushFreed       6 3 0 777 000 1
idle
reuseThree      1 0 0 000 003 0
sizeReusedThree 5 3 0 000 000 0
sizeLiveArray   5 0 0 000 006 0
writeNext       3 2 1 7e7 7e7 0
readNext        4 2 1 000 7e7 0
addToZero       9 2 1 819 000 0
readZero        4 2 1 000 000 0
nop             0 0 0 000 000 0

//--- arrayHeap.f
+incdir+.
arrayHeapPkg.sv
heapAllocator.sv
arraySlot.sv
resultCollector.sv
arrayHeap.sv
heapChecker.sv
arrayHeapTb.sv

//--- runSim.sh
#!/bin/sh
# Build the array heap testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module arrayHeapTb \
  -f arrayHeap.f -o arrayHeapSim || exit 1
output=$(./obj_dir/arrayHeapSim)
echo "$output"
echo "$output" | grep -qx "=== PASS ===" && exit 0 || exit 1

//--- arrayHeapTb.sv
// Array heap testbench
// Reads commands and expected answers from the stimulus file and drives
// them into the heap one per clock, the checker compares the results

`timescale 1ns/1ps

module arrayHeapTb;

  logic                    clock;
  logic                    reset;
  logic                    command;
  arrayHeapPkg::heapOp     op;
  arrayHeapPkg::arrayId    targetId;
  arrayHeapPkg::elemIndex  index;
  arrayHeapPkg::dataWord   in;
  arrayHeapPkg::dataWord   out;
  arrayHeapPkg::heapError  error;
  logic                    done;

  logic [127:0]            testName;           // Name of the command in flight
  arrayHeapPkg::dataWord   expOut;
  arrayHeapPkg::heapError  expError;
  int                      testCount;
  int                      failCount;
  int                      pendingCount;       // Commands the checker still waits on
  int                      loadErrors;
  int                      commandCount;       // Non idle stimulus lines
  int                      cycles;
  int                      cycleLimit;
  logic                    loaded = 1'b0;

  // --------------------
  // Stimulus lines, idle ones included
  // --------------------

  logic                    lineIdle  [$];
  logic [127:0]            lineName  [$];
  arrayHeapPkg::heapOp     lineOp    [$];
  arrayHeapPkg::arrayId    lineId    [$];
  arrayHeapPkg::elemIndex  lineIndex [$];
  arrayHeapPkg::dataWord   lineIn    [$];
  arrayHeapPkg::dataWord   lineOut   [$];
  arrayHeapPkg::heapError  lineError [$];

  arrayHeap arrayHeap_i (
    .clock   (clock),
    .reset   (reset),
    .command (command),
    .op      (op),
    .arrayId (targetId),
    .index   (index),
    .in      (in),
    .out     (out),
    .error   (error),
    .done    (done)
  );

  heapChecker checker_i (
    .clock        (clock),
    .reset        (reset),
    .command      (command),
    .testName     (testName),
    .expOut       (expOut),
    .expError     (expError),
    .out          (out),
    .error        (error),
    .done         (done),
    .testCount    (testCount),
    .failCount    (failCount),
    .pendingCount (pendingCount)
  );

  // Columns are name, op, array, index, in, expected out, expected error
  task automatic loadStimulus();
    int            fd;
    int            fields;
    string         line;
    logic [127:0]  name;
    logic [31:0]   opV;
    logic [31:0]   idV;
    logic [31:0]   indexV;
    logic [31:0]   inV;
    logic [31:0]   outV;
    logic [31:0]   errorV;
    fd = $fopen("heap_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open heap_stimulus.txt");
      loadErrors++;
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() == 0 || line[0] == "#") continue;   // Column notes
      name   = '0;
      fields = $sscanf(line, "%s %h %h %h %h %h %h", name, opV, idV, indexV, inV,
                       outV, errorV);
      if (fields < 1) continue;                          // Blank line
      if (fields == 1 && name == "idle") begin
        lineIdle.push_back(1'b1);                        // Strobe stays low
      end else if (fields == 7) begin
        lineIdle.push_back(1'b0);
        commandCount++;
      end else begin
        $display("Error: malformed stimulus line: %s", line);
        loadErrors++;
        continue;
      end
      lineName.push_back(name);
      lineOp.push_back(arrayHeapPkg::heapOp'(opV[3:0]));
      lineId.push_back(arrayHeapPkg::arrayId'(idV));
      lineIndex.push_back(arrayHeapPkg::elemIndex'(indexV));
      lineIn.push_back(arrayHeapPkg::dataWord'(inV));
      lineOut.push_back(arrayHeapPkg::dataWord'(outV));
      lineError.push_back(arrayHeapPkg::heapError'(errorV[2:0]));
    end
    $fclose(fd);
  endtask

  task automatic driveLine(input int i);
    command  = !lineIdle[i];
    op       = lineOp[i];
    targetId = lineId[i];
    index    = lineIndex[i];
    in       = lineIn[i];
    testName = lineName[i];                              // Expected pair for the checker
    expOut   = lineOut[i];
    expError = lineError[i];
  endtask

  // --------------------
  // Clock, stimulus, timeout
  // --------------------

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;                           // 4 ns period
  end

  initial begin
    reset    = 1'b1;
    command  = 1'b0;
    op       = arrayHeapPkg::opNop;
    targetId = '0;
    index    = '0;
    in       = '0;
    testName = '0;
    expOut   = '0;
    expError = arrayHeapPkg::errNone;
    loadStimulus();
    cycleLimit = lineName.size() + 8 + 20;               // Lines, reset, margin
    loaded     = 1'b1;
    repeat (8) @(posedge clock);
    #1 reset = 1'b0;
    for (int i = 0; i < lineName.size(); i++) begin
      @(posedge clock);
      #1;
      driveLine(i);
    end
    @(posedge clock);
    #1 command = 1'b0;
    while (pendingCount != 0) begin                      // Drain the last results
      @(posedge clock);
      #1;
    end
    @(posedge clock);
    #1;
    $display("Tests: %0d of %0d checked, %0d failed, %0d stimulus errors",
             testCount, commandCount, failCount, loadErrors);
    if (failCount == 0 && loadErrors == 0 && commandCount > 0 &&
        testCount == commandCount) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    while (cycles <= cycleLimit) begin
      @(posedge clock);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- heapChecker.sv
// Heap result checker
// Queues the expected answer of every command and compares it with the
// DUT output in the done cycle that follows

`timescale 1ns/1ps

module heapChecker (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    command,       // Strobe seen by the DUT
  input  logic [127:0]            testName,      // Name and expected answer of it
  input  arrayHeapPkg::dataWord   expOut,
  input  arrayHeapPkg::heapError  expError,
  input  arrayHeapPkg::dataWord   out,
  input  arrayHeapPkg::heapError  error,
  input  logic                    done,
  output int                      testCount,
  output int                      failCount,
  output int                      pendingCount   // Commands still waiting for done
);

  logic [127:0]            nameQ  [$];
  arrayHeapPkg::dataWord   outQ   [$];
  arrayHeapPkg::heapError  errorQ [$];
  logic                    lastCommand;          // Command taken on the previous edge

  always @(posedge clock) begin : compare
    logic [127:0]            name;
    arrayHeapPkg::dataWord   wantOut;
    arrayHeapPkg::heapError  wantError;
    if (reset) begin
      nameQ.delete();
      outQ.delete();
      errorQ.delete();
      lastCommand  = 1'b0;
      testCount    = 0;
      failCount    = 0;
      pendingCount = 0;
    end else begin
      if (lastCommand && !done) begin            // Latency is exactly one cycle
        $display("Error: a command got no done in the next cycle");
        failCount++;
      end
      if (done) begin
        if (nameQ.size() == 0) begin
          $display("Error: done without a pending command");
          failCount++;
        end else begin
          name      = nameQ.pop_front();
          wantOut   = outQ.pop_front();
          wantError = errorQ.pop_front();
          testCount++;
          if (out !== wantOut || error !== wantError) begin
            $display("[FAIL] %0s expected out=%h error=%s, actual out=%h error=%s",
                     name, wantOut, wantError.name(), out, error.name());
            failCount++;
          end else begin
            $display("[PASS] %0s out=%h error=%s", name, out, error.name());
          end
        end
      end
      if (command) begin                         // Answer due on the next edge
        nameQ.push_back(testName);
        outQ.push_back(expOut);
        errorQ.push_back(expError);
      end
      lastCommand  = command;
      pendingCount = nameQ.size();
    end
  end

endmodule

//--- arrayHeap.sv
// Array heap top level
// Allocator, one slot per array and the result collector

`timescale 1ns/1ps
`include "arrayHeap_settings.svh"

module arrayHeap (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     command,     // One command per strobe
  input  arrayHeapPkg::heapOp      op,
  input  arrayHeapPkg::arrayId     arrayId,
  input  arrayHeapPkg::elemIndex   index,
  input  arrayHeapPkg::dataWord    in,
  output arrayHeapPkg::dataWord    out,
  output arrayHeapPkg::heapError   error,
  output logic                     done         // One cycle after command
);

  logic [`HEAP_ARRAYS-1:0]  slotSelect;
  logic [`HEAP_ARRAYS-1:0]  slotClear;
  arrayHeapPkg::dataWord    slotResult [`HEAP_ARRAYS];
  arrayHeapPkg::heapError   slotFault  [`HEAP_ARRAYS];
  arrayHeapPkg::arrayId     allocId;
  logic                     allocIdValid;
  arrayHeapPkg::heapError   allocFault;

  heapAllocator allocator_i (
    .clock        (clock),
    .reset        (reset),
    .command      (command),
    .op           (op),
    .arrayId      (arrayId),
    .slotSelect   (slotSelect),
    .slotClear    (slotClear),
    .allocId      (allocId),
    .allocIdValid (allocIdValid),
    .allocFault   (allocFault)
  );

  // One slot per array, sharing op, index and in
  for (genvar k = 0; k < `HEAP_ARRAYS; k++) begin : slots
    arraySlot slot_i (
      .clock  (clock),
      .reset  (reset),
      .clear  (slotClear[k]),
      .select (slotSelect[k]),
      .op     (op),
      .index  (index),
      .in     (in),
      .result (slotResult[k]),
      .fault  (slotFault[k])
    );
  end

  resultCollector collector_i (
    .clock        (clock),
    .reset        (reset),
    .command      (command),
    .slotSelect   (slotSelect),
    .slotResult   (slotResult),
    .slotFault    (slotFault),
    .allocId      (allocId),
    .allocIdValid (allocIdValid),
    .allocFault   (allocFault),
    .out          (out),
    .error        (error),
    .done         (done)
  );

endmodule

//--- resultCollector.sv
// Result collector
// Picks the allocator or slot answer for the command and registers it,
// giving out, error and done one cycle after the command strobe

`timescale 1ns/1ps
`include "arrayHeap_settings.svh"

module resultCollector (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     command,
  input  logic [`HEAP_ARRAYS-1:0]  slotSelect,              // At most one bit high
  input  arrayHeapPkg::dataWord    slotResult [`HEAP_ARRAYS],
  input  arrayHeapPkg::heapError   slotFault  [`HEAP_ARRAYS],
  input  arrayHeapPkg::arrayId     allocId,
  input  logic                     allocIdValid,
  input  arrayHeapPkg::heapError   allocFault,
  output arrayHeapPkg::dataWord    out,
  output arrayHeapPkg::heapError   error,
  output logic                     done                     // Result valid this cycle
);

  arrayHeapPkg::dataWord   nextOut;
  arrayHeapPkg::heapError  nextError;

  // --------------------
  // Source select
  // --------------------

  always_comb begin
    nextOut   = '0;
    nextError = arrayHeapPkg::errNone;
    if (allocIdValid) begin
      nextOut = arrayHeapPkg::dataWord'(allocId);          // Alloc returns the id
    end else if (allocFault != arrayHeapPkg::errNone) begin
      nextError = allocFault;
    end else begin
      for (int k = 0; k < `HEAP_ARRAYS; k++) begin
        if (slotSelect[k]) begin
          nextOut   = slotResult[k];
          nextError = slotFault[k];
        end
      end
    end
    if (nextError != arrayHeapPkg::errNone) begin
      nextOut = '0;                                         // Zero out on any error
    end
  end

  // --------------------
  // Output registers
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      done  <= 1'b0;
      error <= arrayHeapPkg::errNone;
    end else begin
      done  <= command;
      error <= nextError;                                   // errNone when idle
    end
  end

  always_ff @(posedge clock) begin
    out <= nextOut;
  end

endmodule

//--- arraySlot.sv
// Array slot
// Holds one array and its size, computes each element op combinationally
// and commits it on the clock when selected and fault free

`timescale 1ns/1ps

module arraySlot (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     clear,       // Empty the array, from alloc
  input  logic                     select,      // This slot owns the command
  input  arrayHeapPkg::heapOp      op,
  input  arrayHeapPkg::elemIndex   index,
  input  arrayHeapPkg::dataWord    in,
  output arrayHeapPkg::dataWord    result,
  output arrayHeapPkg::heapError   fault        // Bounds, full, empty, too large
);

  arrayHeapPkg::dataWord   elements [arrayHeapPkg::arrayLength];  // Array storage
  arrayHeapPkg::sizeCount  size;                 // Used length
  arrayHeapPkg::sizeCount  nextSize;
  arrayHeapPkg::sizeCount  lessCount;            // Used elements below in
  arrayHeapPkg::sizeCount  lastSlot;             // size minus one
  arrayHeapPkg::elemIndex  writeIndex;
  arrayHeapPkg::dataWord   writeData;
  arrayHeapPkg::dataWord   sum;                  // Element plus in, wraps
  logic                    writeEnable;
  logic                    inRange;              // Index below size
  logic                    commit;

  assign inRange  = arrayHeapPkg::sizeCount'(index) < size;
  assign lastSlot = size - 1'b1;
  assign sum      = elements[index] + in;
  assign commit   = select && fault == arrayHeapPkg::errNone;

  // --------------------
  // Search
  // --------------------

  always_comb begin
    lessCount = '0;
    for (int i = 0; i < arrayHeapPkg::arrayLength; i++) begin
      if (i < size && elements[i] < in) begin  // Only the used part counts
        lessCount = lessCount + 1'b1;
      end
    end
  end

  // --------------------
  // Element ops
  // --------------------

  always_comb begin
    result      = '0;
    fault       = arrayHeapPkg::errNone;
    nextSize    = size;
    writeEnable = 1'b0;
    writeIndex  = index;
    writeData   = in;
    case (op)
      arrayHeapPkg::opWrite: begin
        writeEnable = 1'b1;
        result      = in;
        if (!inRange) begin
          nextSize = arrayHeapPkg::sizeCount'(index) + 1'b1;  // Grow to cover index
        end
      end
      arrayHeapPkg::opRead: begin
        if (!inRange) fault = arrayHeapPkg::errBounds;
        else result = elements[index];
      end
      arrayHeapPkg::opSize: result = arrayHeapPkg::dataWord'(size);
      arrayHeapPkg::opPush: begin
        if (size == arrayHeapPkg::arrayLength) begin
          fault = arrayHeapPkg::errFull;
        end else begin
          writeEnable = 1'b1;
          writeIndex  = size[$bits(index)-1:0];      // First unused element
          nextSize    = size + 1'b1;
          result      = in;
        end
      end
      arrayHeapPkg::opPop: begin
        if (size == '0) begin
          fault = arrayHeapPkg::errEmpty;
        end else begin
          nextSize = lastSlot;
          result   = elements[lastSlot[$bits(index)-1:0]];  // Value being removed
        end
      end
      arrayHeapPkg::opResize: begin
        if (in > arrayHeapPkg::arrayLength) begin
          fault = arrayHeapPkg::errTooLarge;
        end else begin
          nextSize = arrayHeapPkg::sizeCount'(in);
          result   = in;                             // New size
        end
      end
      arrayHeapPkg::opAdd: begin
        if (!inRange) begin
          fault = arrayHeapPkg::errBounds;
        end else begin
          writeEnable = 1'b1;
          writeData   = sum;
          result      = sum;
        end
      end
      arrayHeapPkg::opLess: result = arrayHeapPkg::dataWord'(lessCount);
      default: begin
      end
    endcase
  end

  // --------------------
  // State update
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      size <= '0;
    end else if (clear) begin
      size <= '0;                                    // Fresh array from alloc
    end else if (commit) begin
      size <= nextSize;
    end
  end

  always_ff @(posedge clock) begin
    if (commit && writeEnable) begin
      elements[writeIndex] <= writeData;
    end
  end

endmodule

//--- heapAllocator.sv
// Heap allocator
// Decodes each command against the allocation state, keeps a LIFO of freed
// arrays and strobes the select or clear line of the addressed array slot

`timescale 1ns/1ps
`include "arrayHeap_settings.svh"

module heapAllocator (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       command,        // One cycle command strobe
  input  arrayHeapPkg::heapOp        op,
  input  arrayHeapPkg::arrayId       arrayId,        // Target array of the command
  output logic [`HEAP_ARRAYS-1:0]    slotSelect,     // Slot runs an element op
  output logic [`HEAP_ARRAYS-1:0]    slotClear,      // Slot empties itself on alloc
  output arrayHeapPkg::arrayId       allocId,        // Id handed out by alloc
  output logic                       allocIdValid,
  output arrayHeapPkg::heapError     allocFault      // Allocation state errors only
);

  localparam int idBits    = $bits(arrayHeapPkg::arrayId);
  localparam int countBits = idBits + 1;             // Counts up to HEAP_ARRAYS

  logic [`HEAP_ARRAYS-1:0] allocated;                // One bit per live array
  logic [countBits-1:0]    highWater;                // Arrays ever handed out
  logic [countBits-1:0]    freeTop;                  // Depth of the free stack
  logic [countBits-1:0]    popSlot;                  // Top entry of the free stack
  arrayHeapPkg::arrayId    freeStack [`HEAP_ARRAYS]; // Freed ids, last in first out
  logic                    freeOk;                   // Free is accepted this cycle

  assign popSlot = freeTop - 1'b1;
  assign freeOk  = command && op == arrayHeapPkg::opFree &&
                   allocFault == arrayHeapPkg::errNone;

  // --------------------
  // Command decode
  // --------------------

  always_comb begin
    slotSelect   = '0;
    slotClear    = '0;
    allocId      = '0;
    allocIdValid = 1'b0;
    allocFault   = arrayHeapPkg::errNone;
    if (command) begin
      case (op)
        arrayHeapPkg::opNop: begin
        end
        arrayHeapPkg::opAlloc: begin
          if (freeTop != '0) begin                   // Reuse the latest freed array
            allocId      = freeStack[popSlot[idBits-1:0]];
            allocIdValid = 1'b1;
          end else if (highWater < `HEAP_ARRAYS) begin  // Next never-used array
            allocId      = highWater[idBits-1:0];
            allocIdValid = 1'b1;
          end else begin
            allocFault = arrayHeapPkg::errNoSpace;
          end
          if (allocIdValid) begin
            slotClear[allocId] = 1'b1;               // New array starts empty
          end
        end
        default: begin
          if (!allocated[arrayId]) begin
            allocFault = arrayHeapPkg::errNotAllocated;
          end else if (op != arrayHeapPkg::opFree) begin
            slotSelect[arrayId] = 1'b1;              // Hand element op to the slot
          end
        end
      endcase
    end
  end

  // --------------------
  // Allocation state
  // --------------------

  always_ff @(posedge clock) begin
    if (reset) begin
      allocated <= '0;
      highWater <= '0;
      freeTop   <= '0;
    end else if (allocIdValid) begin
      allocated[allocId] <= 1'b1;
      if (freeTop != '0) begin
        freeTop <= popSlot;                          // Pop the reused id
      end else begin
        highWater <= highWater + 1'b1;
      end
    end else if (freeOk) begin
      allocated[arrayId] <= 1'b0;
      freeTop            <= freeTop + 1'b1;
    end
  end

  // Stack never overflows, only live arrays can be freed
  always_ff @(posedge clock) begin
    if (freeOk) begin
      freeStack[freeTop[idBits-1:0]] <= arrayId;
    end
  end

endmodule

//--- arrayHeapPkg.sv
// Array heap shared types
// Opcodes, error codes and the word widths used across the heap

`include "arrayHeap_settings.svh"

package arrayHeapPkg;

  // --------------------
  // Command and status codes
  // --------------------

  typedef enum logic [3:0] {
    opNop,                                    // No operation, still answers
    opAlloc,                                  // Allocate an array, returns its id
    opFree,                                   // Release an array for reuse
    opWrite,                                  // Write an element
    opRead,                                   // Read an element
    opSize,                                   // Current size of the array
    opPush,                                   // Append to the end
    opPop,                                    // Remove from the end
    opResize,                                 // Set the size directly
    opAdd,                                    // Add to an element, new value out
    opLess                                    // Count used elements below in
  } heapOp;

  typedef enum logic [2:0] {
    errNone,                                  // Command succeeded
    errNotAllocated,                          // Array is free or never handed out
    errNoSpace,                               // All arrays in use
    errBounds,                                // Index at or past the size
    errFull,                                  // Push onto a full array
    errEmpty,                                 // Pop from an empty array
    errTooLarge                               // Resize past the array length
  } heapError;

  // --------------------
  // Widths
  // --------------------

  typedef logic [`HEAP_DATA_BITS-1:0]        dataWord;   // One element
  typedef logic [$clog2(`HEAP_ARRAYS)-1:0]   arrayId;    // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]       elemIndex;  // Element position
  typedef logic [`HEAP_INDEX_BITS:0]         sizeCount;  // Size up to full length

  localparam int arrayLength = 2 ** `HEAP_INDEX_BITS;    // Elements per array

endpackage

//--- arrayHeap_settings.svh
// Array heap sizing
// Number of arrays, element index width and element data width

`ifndef ARRAYHEAP_SETTINGS_SVH
`define ARRAYHEAP_SETTINGS_SVH

// --------------------
// Heap geometry
// --------------------

`define HEAP_ARRAYS     4   // Array slots, power of two
`define HEAP_INDEX_BITS 3   // Index bits, array length of 8
`define HEAP_DATA_BITS  12  // Bits per element

`endif
